// File: ps2_kbd_ctrl.f
common/ps2_pkg.sv
ps2_rx/ps2_line_sync.sv
ps2_rx/ps2_frame_rx.sv
design/ps2_byte_fifo.sv
design/ps2_kbd_ctrl.sv
test/ps2_kbd_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# build and run the PS/2 receiver testbench, exit status is the verdict
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f ps2_kbd_ctrl.f --top-module ps2_kbd_ctrl_tb \
    -o ps2_kbd_ctrl_sim \
    && ./obj_dir/ps2_kbd_ctrl_sim \
    || exit 1

// File: test/ps2_kbd_ctrl_tb.sv
`timescale 1ns/10ps

module ps2_kbd_ctrl_tb;
    import ps2_pkg::*;

    localparam int NUM_ROWS      = 16;
    localparam int RESET_CYCLES  = 10;
    localparam int KBD_HALF      = 10;               // core cycles per kbd_clk half period
    localparam int FRAME_GAP     = 2 * KBD_HALF;     // bus idle between frames
    localparam int STALL_EXTRA   = 50;               // idle beyond IDLE_LIMIT on a cut frame
    localparam int CUT_BITS      = 5;
    localparam int READY_TIMEOUT = 4 * KBD_HALF;
    // PS2_FRAME_BITS * 20 cycles of 10 ns per frame plus slack
    localparam int WATCHDOG_NS   = NUM_ROWS * PS2_FRAME_BITS * 20 * 10
                                 + (IDLE_LIMIT + NUM_ROWS * 60 + 100) * 10;

    // one stimulus row with its expected outcome
    typedef struct packed {
        ps2_byte_t  data;
        logic       bad_par;   // flip the parity bit
        logic       bad_stop;  // send stop bit as 0
        logic       cut;       // stop after CUT_BITS bits and go quiet
        logic       scan_en;   // scanf_en level during the frame
        logic       exp_err;   // one error pulse expected
        logic       exp_q;     // byte goes into the queue if there is room
        logic [2:0] reads;     // core reads after the frame
    } row_t;

    logic       kbd_clk;
    logic       data_in_kc;
    logic       core_clk;
    logic       rst;
    logic       core_read_en;
    logic       scanf_en;
    ps2_byte_t  data_out_cc;
    logic       valid_cc;
    logic       error;
    logic       data_ready;

    row_t       table_rows [NUM_ROWS];
    ps2_byte_t  expect_q [$];   // bytes the core should read in order
    int         err_seen = 0;   // error pulses so far
    integer     seed = 32'h37ba;

    ps2_kbd_ctrl dut_i (
        .kbd_clk      (kbd_clk),
        .data_in_kc   (data_in_kc),
        .core_clk     (core_clk),
        .rst          (rst),
        .core_read_en (core_read_en),
        .data_out_cc  (data_out_cc),
        .valid_cc     (valid_cc),
        .error        (error),
        .data_ready   (data_ready),
        .scanf_en     (scanf_en)
    );

    initial core_clk = 1'b0;
    always #5 core_clk = ~core_clk;  // 10 ns period

    // error changes on posedge and is steady at negedge
    always @(negedge core_clk) begin
        if (error) begin
            err_seen <= err_seen + 1;
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string name);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %b, actual %b",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_byte(input ps2_byte_t actual, input ps2_byte_t expected,
                              input string name);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %02h, actual %02h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string name);
        if (actual != expected) begin
            abort_run($sformatf("Error at %0t ns: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
        end
    endtask

    function automatic row_t make_row(input ps2_byte_t data, input logic bad_par,
                                      input logic bad_stop, input logic cut,
                                      input logic scan_en, input logic exp_err,
                                      input logic exp_q, input logic [2:0] reads);
        row_t r;
        r = '{data, bad_par, bad_stop, cut, scan_en, exp_err, exp_q, reads};
        return r;
    endfunction

    function automatic ps2_byte_t random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic fill_table();
        // good frames each read back right away
        table_rows[0]  = make_row(8'h1c, 0, 0, 0, 1, 0, 1, 3'd1);
        table_rows[1]  = make_row(8'hf0, 0, 0, 0, 1, 0, 1, 3'd1);
        table_rows[2]  = make_row(random_byte(), 0, 0, 0, 1, 0, 1, 3'd1);
        table_rows[3]  = make_row(random_byte(), 0, 0, 0, 1, 0, 1, 3'd1);
        // bad parity then bad stop bit
        table_rows[4]  = make_row(8'h5a, 1, 0, 0, 1, 1, 0, 3'd0);
        table_rows[5]  = make_row(8'h33, 0, 1, 0, 1, 1, 0, 3'd0);
        // scanf_en low drops the byte quietly
        table_rows[6]  = make_row(8'h29, 0, 0, 0, 0, 0, 0, 3'd0);
        table_rows[7]  = make_row(random_byte(), 0, 0, 0, 0, 0, 0, 3'd0);
        // six frames with no reads and the last two find the queue full
        table_rows[8]  = make_row(8'h45, 0, 0, 0, 1, 0, 1, 3'd0);
        table_rows[9]  = make_row(random_byte(), 0, 0, 0, 1, 0, 1, 3'd0);
        table_rows[10] = make_row(8'h16, 0, 0, 0, 1, 0, 1, 3'd0);
        table_rows[11] = make_row(random_byte(), 0, 0, 0, 1, 0, 1, 3'd0);
        table_rows[12] = make_row(8'h1e, 0, 0, 0, 1, 0, 1, 3'd0);
        table_rows[13] = make_row(random_byte(), 0, 0, 0, 1, 0, 1, 3'd5);  // 4 bytes + empty read
        // stalled frame followed by a good one that must still line up
        table_rows[14] = make_row(8'haa, 0, 0, 1, 1, 0, 0, 3'd0);
        table_rows[15] = make_row(8'h76, 0, 0, 0, 1, 0, 1, 3'd1);
    endtask

    // keyboard model with data changing while kbd_clk is high
    task automatic send_frame(input row_t r);
        logic [PS2_FRAME_BITS-1:0] bits;
        int                        n_bits;
        int                        i;
        bits[0]   = 1'b0;                    // start
        bits[8:1] = r.data;                  // lsb first on the wire
        bits[9]   = ~(^r.data) ^ r.bad_par;  // odd parity
        bits[10]  = ~r.bad_stop;
        n_bits    = r.cut ? CUT_BITS : PS2_FRAME_BITS;
        for (i = 0; i < n_bits; i++) begin
            data_in_kc = bits[i];
            repeat (KBD_HALF) @(negedge core_clk);
            kbd_clk = 1'b0;   // receiver samples here
            repeat (KBD_HALF) @(negedge core_clk);
            kbd_clk = 1'b1;
        end
        data_in_kc = 1'b1;
        if (r.cut) begin
            repeat (IDLE_LIMIT + STALL_EXTRA) @(negedge core_clk);  // let the receiver give up
        end
        repeat (FRAME_GAP) @(negedge core_clk);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (data_ready !== 1'b1) begin
            if (n == READY_TIMEOUT) begin
                abort_run("data_ready never went high after a good frame");
            end
            @(negedge core_clk);
            n++;
        end
    endtask

    // one-cycle read strobe with outputs combinational in that cycle
    task automatic read_byte();
        ps2_byte_t exp;
        core_read_en = 1'b1;
        #1;
        if (expect_q.size() == 0) begin
            check_bit(valid_cc, 1'b0, "valid_cc");
        end else begin
            exp = expect_q.pop_front();
            check_bit(valid_cc, 1'b1, "valid_cc");
            check_byte(data_out_cc, exp, "data_out_cc");
        end
        @(negedge core_clk);
        core_read_en = 1'b0;
        @(negedge core_clk);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run("watchdog expired");
    end

    initial begin
        row_t row;
        int   err_before;
        int   pulses;
        int   i;
        int   k;
        kbd_clk      = 1'b1;  // bus idle
        data_in_kc   = 1'b1;
        rst          = 1'b1;
        core_read_en = 1'b0;
        scanf_en     = 1'b0;
        fill_table();
        repeat (RESET_CYCLES) @(negedge core_clk);
        rst = 1'b0;
        @(negedge core_clk);
        check_bit(error, 1'b0, "error");
        check_bit(valid_cc, 1'b0, "valid_cc");
        check_bit(data_ready, 1'b0, "data_ready");
        read_byte();  // read of the empty queue must be ignored

        for (i = 0; i < NUM_ROWS; i++) begin
            row        = table_rows[i];
            err_before = err_seen;
            scanf_en   = row.scan_en;
            send_frame(row);
            if (row.exp_q && expect_q.size() < FIFO_DEPTH) begin
                expect_q.push_back(row.data);  // dropped when the queue is full
            end
            if (expect_q.size() != 0) begin
                wait_ready();
            end
            check_bit(data_ready, logic'(expect_q.size() != 0), "data_ready");
            pulses = err_seen - err_before;
            check_count(pulses, int'(row.exp_err), "error pulses");
            for (k = 0; k < int'(row.reads); k++) begin
                read_byte();
            end
            check_bit(data_ready, logic'(expect_q.size() != 0), "data_ready");
        end

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: design/ps2_kbd_ctrl.sv
`timescale 1ns/10ps

module ps2_kbd_ctrl (
    // keyboard side
    input  logic              kbd_clk,
    input  logic              data_in_kc,
    // core side
    input  logic              core_clk,
    input  logic              rst,
    input  logic              core_read_en,  // read strobe
    output ps2_pkg::ps2_byte_t data_out_cc,
    output logic              valid_cc,      // byte taken this cycle
    output logic              error,         // bad frame pulse
    // control / status
    output logic              data_ready,    // at least one byte queued
    input  logic              scanf_en       // allow bytes into the queue
);
    import ps2_pkg::*;

    logic       bit_stb;
    logic       bit_val;
    logic       frame_done;
    ps2_frame_t frame;
    logic       frame_bad;
    logic       push;
    logic       fifo_full;
    logic       fifo_empty;

    ps2_line_sync ps2_line_sync_i (
        .core_clk   (core_clk),
        .rst        (rst),
        .kbd_clk    (kbd_clk),
        .data_in_kc (data_in_kc),
        .bit_stb    (bit_stb),
        .bit_val    (bit_val)
    );

    ps2_frame_rx ps2_frame_rx_i (
        .core_clk   (core_clk),
        .rst        (rst),
        .bit_stb    (bit_stb),
        .bit_val    (bit_val),
        .frame_done (frame_done),
        .frame      (frame)
    );

    assign frame_bad = frame.parity_err | frame.framing_err;
    // good byte goes in only when enabled and there is room, otherwise dropped
    assign push      = frame_done & ~frame_bad & scanf_en & ~fifo_full;
    assign error     = frame_done & frame_bad;  // reported even with scanf_en low

    ps2_byte_fifo ps2_byte_fifo_i (
        .core_clk  (core_clk),
        .rst       (rst),
        .push      (push),
        .push_data (frame.data),
        .pop       (core_read_en),
        .pop_data  (data_out_cc),
        .full      (fifo_full),
        .empty     (fifo_empty)
    );

    assign data_ready = ~fifo_empty;
    assign valid_cc   = ~fifo_empty & core_read_en;  // empty reads are ignored

endmodule

// File: design/ps2_byte_fifo.sv
`timescale 1ns/10ps

module ps2_byte_fifo (
    input  logic              core_clk,
    input  logic              rst,
    input  logic              push,       // caller guarantees not full
    input  ps2_pkg::ps2_byte_t push_data,
    input  logic              pop,        // ignored while empty
    output ps2_pkg::ps2_byte_t pop_data,  // head, shown ahead of pop
    output logic              full,
    output logic              empty
);
    import ps2_pkg::*;

    ps2_byte_t               mem [FIFO_DEPTH];  // storage, no reset needed
    logic [FIFO_PTR_W-1:0]   wr_ptr;
    logic [FIFO_PTR_W-1:0]   rd_ptr;
    logic [FIFO_PTR_W:0]     count;             // 0 .. FIFO_DEPTH
    logic                    pop_ok;

    assign pop_ok   = pop & ~empty;
    assign full     = (count == FIFO_DEPTH);
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];  // zero latency read

    // write side
    always_ff @(posedge core_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge core_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge core_clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

endmodule

// File: ps2_rx/ps2_frame_rx.sv
`timescale 1ns/10ps

module ps2_frame_rx (
    input  logic               core_clk,
    input  logic               rst,
    input  logic               bit_stb,     // one strobe per received bit
    input  logic               bit_val,     // the bit itself
    output logic               frame_done,  // one cycle after the stop bit
    output ps2_pkg::ps2_frame_t frame       // valid while frame_done is high
);
    import ps2_pkg::*;

    logic [$clog2(PS2_FRAME_BITS)-1:0] bit_cnt;   // position within the frame
    logic [$clog2(IDLE_LIMIT+1)-1:0]   idle_cnt;  // cycles since last bit in a partial frame
    ps2_byte_t                         data_sr;   // data bits, lsb arrives first
    logic                              start_bit;
    logic                              parity_acc; // xor of data and parity bits
    logic                              last_bit;
    logic                              idle_expired;

    assign last_bit     = (bit_cnt == PS2_STOP_POS);
    assign idle_expired = (idle_cnt == IDLE_LIMIT - 1);

    // control: bit position, stall timeout and done strobe
    always_ff @(posedge core_clk) begin
        if (rst) begin
            bit_cnt    <= '0;
            idle_cnt   <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;  // pulse only
            if (bit_stb) begin
                idle_cnt <= '0;  // any edge restarts the stall timer
                if (last_bit) begin
                    bit_cnt    <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (bit_cnt != '0) begin
                // mid-frame with no edge: count toward the idle limit
                if (idle_expired) begin
                    // keyboard went quiet, drop the partial frame silently
                    // so the next start bit is taken as bit 0
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // payload: shift, parity and check results
    always_ff @(posedge core_clk) begin
        if (bit_stb) begin
            if (bit_cnt == PS2_START_POS) begin
                start_bit  <= bit_val;
                parity_acc <= 1'b0;  // fresh frame
            end else if (bit_cnt < PS2_PARITY_POS) begin
                data_sr    <= {bit_val, data_sr[PS2_DATA_BITS-1:1]};  // lsb first
                parity_acc <= parity_acc ^ bit_val;
            end else if (bit_cnt == PS2_PARITY_POS) begin
                parity_acc <= parity_acc ^ bit_val;  // odd parity -> acc ends at 1
            end else begin
                // stop bit: publish the frame alongside frame_done
                frame.data        <= data_sr;
                frame.parity_err  <= ~parity_acc;
                frame.framing_err <= start_bit | ~bit_val;
            end
        end
    end

endmodule

// File: ps2_rx/ps2_line_sync.sv
`timescale 1ns/10ps

module ps2_line_sync (
    input  logic core_clk,
    input  logic rst,
    input  logic kbd_clk,     // keyboard clock, async to core_clk
    input  logic data_in_kc,  // keyboard data, async to core_clk
    output logic bit_stb,     // one cycle per kbd_clk falling edge
    output logic bit_val      // data line value at that edge
);
    import ps2_pkg::*;

    logic [SYNC_STAGES-1:0] clk_sync;  // kbd_clk synchronizer chain
    logic [SYNC_STAGES-1:0] dat_sync;  // data_in_kc synchronizer chain
    logic                   clk_prev;  // last synchronized kbd_clk, for edge detect
    logic                   clk_fall;

    // both lines share the same depth so the data bit lines up with its clock edge
    assign clk_fall = clk_prev & ~clk_sync[SYNC_STAGES-1];

    always_ff @(posedge core_clk) begin
        if (rst) begin
            clk_sync <= '1;     // bus idles high
            dat_sync <= '1;
            clk_prev <= 1'b1;
            bit_stb  <= 1'b0;
            bit_val  <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[SYNC_STAGES-2:0], kbd_clk};
            dat_sync <= {dat_sync[SYNC_STAGES-2:0], data_in_kc};
            clk_prev <= clk_sync[SYNC_STAGES-1];
            // registered strobe, lands SYNC_STAGES+1 cycles after the edge
            bit_stb  <= clk_fall;
            bit_val  <= dat_sync[SYNC_STAGES-1];  // sampled at the same instant as the edge
        end
    end

endmodule

// File: common/ps2_pkg.sv
package ps2_pkg;

    // ps2 frame layout: start, 8 data bits lsb first, odd parity, stop
    localparam int PS2_DATA_BITS  = 8;
    localparam int PS2_FRAME_BITS = 11;                  // falling edges of kbd_clk per frame
    localparam int PS2_START_POS  = 0;                   // start bit, must be 0
    localparam int PS2_PARITY_POS = PS2_DATA_BITS + 1;   // odd parity over the data bits
    localparam int PS2_STOP_POS   = PS2_FRAME_BITS - 1;  // stop bit, must be 1

    // receive queue toward the core
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

    // core_clk cycles with no kbd_clk falling edge before a partial frame is dropped
    // (a full kbd_clk period is far shorter than this)
    localparam int IDLE_LIMIT = 200;

    // flops on each ps2 line when crossing into core_clk
    localparam int SYNC_STAGES = 2;

    // one scan-code byte as seen by the core
    typedef logic [PS2_DATA_BITS-1:0] ps2_byte_t;

    // result of one complete frame
    typedef struct packed {
        ps2_byte_t data;         // assembled byte
        logic      parity_err;   // even count of ones over data + parity
        logic      framing_err;  // start bit high or stop bit low
    } ps2_frame_t;

endpackage
